//--- design/l1d_pkg.sv
package l1d_pkg;

    // Cache geometry
    localparam int TAG_W    = 52;
    localparam int INDEX_W  = 6;

    // One set per index value
    localparam int NUM_SETS = 1 << INDEX_W;

    // Address fields of a read request
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    // Miss controller states
    // ST_LOOKUP is the cycle where the registered compare result is seen
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_LOOKUP  = 2'd1,
        ST_L2_REQ  = 2'd2,
        ST_L2_WAIT = 2'd3
    } miss_state_e;

endpackage

//--- design/l1d_tag_store.sv
module l1d_tag_store #(
    parameter int TAG_W   = l1d_pkg::TAG_W,
    parameter int INDEX_W = l1d_pkg::INDEX_W
) (
    input  logic               clk,
    input  logic               nrst,
    input  logic               req,
    input  logic [TAG_W-1:0]   tag,
    input  logic [INDEX_W-1:0] index,
    input  logic               flush,
    input  logic               fill,
    output logic               lookup_hit
);

    localparam int SETS = 1 << INDEX_W;

    // Tag array and per-set valid bits
    logic [TAG_W-1:0]   tag_mem [SETS];
    logic [SETS-1:0]    valid;

    // Request fields held for the refill write
    logic [TAG_W-1:0]   req_tag;
    logic [INDEX_W-1:0] req_index;

    logic               set_match;

    // Stored tag is only meaningful when the set is valid
    assign set_match = valid[index] && (tag_mem[index] == tag);

    // Capture the request address on the strobe
    always_ff @(posedge clk) begin
        if (req) begin
            req_tag   <= tag;
            req_index <= index;
        end
    end

    // Compare result is seen by the controller in the cycle after req
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            lookup_hit <= 1'b0;
        end else begin
            lookup_hit <= req && set_match;
        end
    end

    // Flush clears all sets and fill marks the refilled set
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            valid <= '0;
        end else if (flush) begin
            valid <= '0;
        end else if (fill) begin
            valid[req_index] <= 1'b1;
        end
    end

    // New tag lands together with the valid bit
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[req_index] <= req_tag;
        end
    end

    // Flush is only legal while the controller is idle, and fill only
    // happens at the end of a miss, so the two never meet
    a_no_fill_during_flush : assert property (
        @(posedge clk) disable iff (!nrst)
        !(fill && flush)
    ) else $error("fill and flush asserted together");

endmodule

//--- design/l1d_miss_ctrl.sv
module l1d_miss_ctrl (
    input  logic clk,
    input  logic nrst,
    input  logic req,
    input  logic lookup_hit,
    input  logic l2_ready,
    output logic stall,
    output logic hit,
    output logic l2_read,
    output logic fill,
    output logic refill
);

    l1d_pkg::miss_state_e state;
    l1d_pkg::miss_state_e state_next;

    // State register
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= l1d_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            l1d_pkg::ST_IDLE: begin
                if (req) begin
                    state_next = l1d_pkg::ST_LOOKUP;
                end
            end
            l1d_pkg::ST_LOOKUP: begin
                // Hit ends the request here, miss goes out to level two
                if (lookup_hit) begin
                    state_next = l1d_pkg::ST_IDLE;
                end else begin
                    state_next = l1d_pkg::ST_L2_REQ;
                end
            end
            l1d_pkg::ST_L2_REQ: begin
                state_next = l1d_pkg::ST_L2_WAIT;
            end
            l1d_pkg::ST_L2_WAIT: begin
                if (l2_ready) begin
                    state_next = l1d_pkg::ST_IDLE;
                end
            end
            default: begin
                state_next = l1d_pkg::ST_IDLE;
            end
        endcase
    end

    // Outputs decoded from the state
    always_comb begin
        stall   = (state != l1d_pkg::ST_IDLE);
        hit     = (state == l1d_pkg::ST_LOOKUP) && lookup_hit;
        l2_read = (state == l1d_pkg::ST_L2_REQ);
        // Tag write happens on the same edge that samples l2_ready
        fill    = (state == l1d_pkg::ST_L2_WAIT) && l2_ready;
    end

    // Refill strobe follows the tag write by one cycle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            refill <= 1'b0;
        end else begin
            refill <= fill;
        end
    end

    // Requester must hold off while a request is in flight
    a_req_only_idle : assert property (
        @(posedge clk) disable iff (!nrst)
        req |-> (state == l1d_pkg::ST_IDLE)
    ) else $error("req seen while stall is high");

    // Level two answers only to an outstanding read
    a_l2_ready_only_wait : assert property (
        @(posedge clk) disable iff (!nrst)
        l2_ready |-> (state == l1d_pkg::ST_L2_WAIT)
    ) else $error("l2_ready seen outside a pending miss");

endmodule

//--- design/l1d_cache_ctrl.sv
module l1d_cache_ctrl #(
    parameter int TAG_W   = l1d_pkg::TAG_W,
    parameter int INDEX_W = l1d_pkg::INDEX_W
) (
    input  logic            clk,
    input  logic            nrst,
    input  logic            req,
    input  l1d_pkg::tag_t   tag,
    input  l1d_pkg::index_t index,
    input  logic            flush,
    input  logic            l2_ready,
    output logic            stall,
    output logic            hit,
    output logic            l2_read,
    output logic            refill
);

    // Compare result from the tag store to the controller
    logic lookup_hit;

    // Tag write request from the controller back to the tag store
    logic fill;

    l1d_tag_store #(
        .TAG_W   (TAG_W),
        .INDEX_W (INDEX_W)
    ) u_tag_store (
        .clk        (clk),
        .nrst       (nrst),
        .req        (req),
        .tag        (tag),
        .index      (index),
        .flush      (flush),
        .fill       (fill),
        .lookup_hit (lookup_hit)
    );

    l1d_miss_ctrl u_miss_ctrl (
        .clk        (clk),
        .nrst       (nrst),
        .req        (req),
        .lookup_hit (lookup_hit),
        .l2_ready   (l2_ready),
        .stall      (stall),
        .hit        (hit),
        .l2_read    (l2_read),
        .fill       (fill),
        .refill     (refill)
    );

    // Flush only between requests
    a_flush_when_idle : assert property (
        @(posedge clk) disable iff (!nrst)
        flush |-> (!stall && !req)
    ) else $error("flush asserted during a request");

endmodule

//--- tb/l1d_cache_ctrl_tb.sv
module l1d_cache_ctrl_tb;

    typedef enum logic {OP_READ, OP_FLUSH} op_e;

    typedef struct {
        op_e             op;
        l1d_pkg::tag_t   tag;
        l1d_pkg::index_t index;
        int              delay;
    } row_t;

    logic            clk;
    logic            nrst;
    logic            req;
    l1d_pkg::tag_t   tag;
    l1d_pkg::index_t index;
    logic            flush;
    logic            l2_ready;
    logic            stall;
    logic            hit;
    logic            l2_read;
    logic            refill;

    integer seed;
    row_t   stim_q[$];
    int     error_count;
    int     pass_count;
    int     fail_count;
    int     cycle_count;
    int     cycle_limit;

    // Reference tag model
    logic          model_valid [l1d_pkg::NUM_SETS];
    l1d_pkg::tag_t model_tag   [l1d_pkg::NUM_SETS];

    l1d_cache_ctrl #(
        .TAG_W   (l1d_pkg::TAG_W),
        .INDEX_W (l1d_pkg::INDEX_W)
    ) u_dut (
        .clk      (clk),
        .nrst     (nrst),
        .req      (req),
        .tag      (tag),
        .index    (index),
        .flush    (flush),
        .l2_ready (l2_ready),
        .stall    (stall),
        .hit      (hit),
        .l2_read  (l2_read),
        .refill   (refill)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Run timed out after %0d cycles without finishing the table", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED at %0t: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    function automatic l1d_pkg::tag_t random_tag();
        logic [63:0] wide;
        wide = {$random(seed), $random(seed)};
        return wide[l1d_pkg::TAG_W-1:0];
    endfunction

    function automatic void add_read(input l1d_pkg::tag_t t, input int idx, input int delay);
        row_t row;
        row.op    = OP_READ;
        row.tag   = t;
        row.index = idx;
        row.delay = delay;
        stim_q.push_back(row);
    endfunction

    function automatic void add_flush();
        row_t row;
        row.op    = OP_FLUSH;
        row.tag   = '0;
        row.index = '0;
        row.delay = 0;
        stim_q.push_back(row);
    endfunction

    task automatic apply_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        check_value("stall", 0, stall);
    endtask

    // Outputs are sampled at the falling edge and l2_read is answered after the row's delay
    task automatic apply_read(input l1d_pkg::tag_t rd_tag, input l1d_pkg::index_t rd_index,
                              input int delay, input logic expect_hit);
        int   stall_cycles;
        int   hit_pulses;
        int   l2_pulses;
        int   refill_pulses;
        int   refill_stalled;
        int   countdown;
        logic armed;
        logic done;
        stall_cycles   = 0;
        hit_pulses     = 0;
        l2_pulses      = 0;
        refill_pulses  = 0;
        refill_stalled = 0;
        countdown      = 0;
        armed          = 1'b0;
        done           = 1'b0;
        @(posedge clk);
        req   <= 1'b1;
        tag   <= rd_tag;
        index <= rd_index;
        @(posedge clk);
        req <= 1'b0;
        while (!done) begin
            @(negedge clk);
            if (hit) hit_pulses++;
            if (l2_read) begin
                l2_pulses++;
                armed     = 1'b1;
                countdown = delay;
            end
            if (refill) begin
                refill_pulses++;
                if (stall) refill_stalled++;
            end
            if (stall) stall_cycles++;
            else done = 1'b1;
            if (!done) begin
                @(posedge clk);
                if (l2_ready) begin
                    l2_ready <= 1'b0;
                end else if (armed) begin
                    if (countdown == 0) begin
                        l2_ready <= 1'b1;
                        armed = 1'b0;
                    end else begin
                        countdown--;
                    end
                end
            end
        end
        check_value("hit", expect_hit ? 1 : 0, hit_pulses);
        check_value("l2_read", expect_hit ? 0 : 1, l2_pulses);
        check_value("refill", expect_hit ? 0 : 1, refill_pulses);
        check_value("refill with stall high", 0, refill_stalled);
        // A hit stalls one cycle and a miss stalls for lookup, l2 request and the wait
        check_value("stall", expect_hit ? 1 : 3 + delay, stall_cycles);
    endtask

    initial begin
        l1d_pkg::tag_t t0;
        l1d_pkg::tag_t t1;
        l1d_pkg::tag_t ta [4];
        int            idx [4];
        int            sum_delay;
        int            errors_before;
        logic          expect_hit;
        clk      = 1'b0;
        nrst     = 1'b0;
        req      = 1'b0;
        tag      = '0;
        index    = '0;
        flush    = 1'b0;
        l2_ready = 1'b0;
        seed = 92959;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        cycle_count = 0;
        cycle_limit = 0;
        foreach (model_valid[s]) begin
            model_valid[s] = 1'b0;
            model_tag[s]   = '0;
        end
        idx = '{12, 40, 63, 0};
        t0 = random_tag();
        t1 = random_tag();
        add_read(t0, 5, 2);
        add_read(t0, 5, 0);
        add_read(t1, 5, 0);
        add_read(t0, 5, 3);
        add_read(t0, 5, 0);
        for (int k = 0; k < 4; k++) begin
            ta[k] = random_tag();
            add_read(ta[k], idx[k], $unsigned($random(seed)) % 6);
        end
        for (int k = 0; k < 4; k++) add_read(ta[k], idx[k], 0);
        // Tag of set 12 looked up in set 13 must still miss
        add_read(ta[0], 13, 1);
        add_flush();
        add_read(t0, 5, 1);
        for (int k = 0; k < 4; k++) add_read(ta[k], idx[k], 1);
        add_read(t0, 5, 0);
        sum_delay = 0;
        foreach (stim_q[n]) sum_delay += stim_q[n].delay;
        cycle_limit = 10 + sum_delay + 4 * stim_q.size() + 200;

        repeat (10) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        errors_before = error_count;
        check_value("stall", 0, stall);
        check_value("hit", 0, hit);
        check_value("l2_read", 0, l2_read);
        check_value("refill", 0, refill);
        if (error_count == errors_before) pass_count++;
        else fail_count++;
        $display("test reset: outputs idle, %s", (error_count == errors_before) ? "ok" : "FAILED");

        foreach (stim_q[n]) begin
            errors_before = error_count;
            if (stim_q[n].op == OP_FLUSH) begin
                apply_flush();
                foreach (model_valid[s]) model_valid[s] = 1'b0;
                $display("test %0d: flush, %s", n,
                         (error_count == errors_before) ? "ok" : "FAILED");
            end else begin
                expect_hit = model_valid[stim_q[n].index] &&
                             (model_tag[stim_q[n].index] == stim_q[n].tag);
                apply_read(stim_q[n].tag, stim_q[n].index, stim_q[n].delay, expect_hit);
                if (!expect_hit) begin
                    model_valid[stim_q[n].index] = 1'b1;
                    model_tag[stim_q[n].index]   = stim_q[n].tag;
                end
                $display("test %0d: read index %0d tag %h, %s, %s", n, stim_q[n].index,
                         stim_q[n].tag, expect_hit ? "hit" : "miss",
                         (error_count == errors_before) ? "ok" : "FAILED");
            end
            if (error_count == errors_before) pass_count++;
            else fail_count++;
        end

        $display("Tests passed: %0d, failed: %0d, check errors: %0d",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- files.f
design/l1d_pkg.sv
design/l1d_tag_store.sv
design/l1d_miss_ctrl.sv
design/l1d_cache_ctrl.sv
tb/l1d_cache_ctrl_tb.sv

//--- Bender.yml
package:
  name: l1d_cache_ctrl

dependencies: {}

sources:
  # Design sources, package first
  - files:
      - design/l1d_pkg.sv
      - design/l1d_tag_store.sv
      - design/l1d_miss_ctrl.sv
      - design/l1d_cache_ctrl.sv

  # Testbench
  - target: test
    files:
      - tb/l1d_cache_ctrl_tb.sv
